/* build.f */
hdl/game_pkg.sv
hdl/link_if.sv
hdl/game_core.sv
hdl/uart_link.sv
hdl/seg_display.sv
hdl/game_top.sv
tb/game_props.sv
tb/tb_game_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_game_top \
    -f build.f

./obj_dir/Vtb_game_top > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

/* tb/tb_game_top.sv */
`timescale 1ns/100ps

module tb_game_top import game_pkg::*; ();

    typedef enum logic [2:0] {
        A_IDLE, A_PRESS, A_FIRE, A_FIRE2, A_RX, A_WAIT_TX
    } action_e;

    typedef struct packed {
        action_e     act;
        logic [7:0]  val;
        game_state_e st;
        logic        tx_chk;
        link_op_e    op;
        logic        disp;
        logic [2:0]  hits;
        logic [3:0]  shots;
    } step_t;

    localparam int         NSTEPS = 23;
    localparam int         FRAME  = 10 * BAUD_DIV;
    localparam logic [7:0] B_GAME = 8'd0;
    localparam logic [7:0] B_MENU = 8'd1;
    localparam logic [7:0] B_VICT = 8'd2;
    localparam logic [7:0] B_OVER = 8'd3;

    logic        clk;
    logic        rst_n;
    logic        game_button;
    logic        menu_button;
    logic        victory_button;
    logic        game_over;
    logic        fire;
    logic        rx;
    logic        tx;
    logic [3:0]  an;
    logic [7:0]  seg;
    game_state_e state;

    step_t steps [NSTEPS];
    int    n_value_err;
    int    n_timeout_err;

    game_top UUT (.*);

    always #20 clk = ~clk;

    task automatic check_state(input game_state_e exp, input game_state_e act);
        if (act !== exp) begin
            $display("CHECK FAILED state: expected %h, got %h", exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_op(input link_op_e exp, input link_op_e act);
        if (act !== exp) begin
            $display("CHECK FAILED tx byte: expected %h, got %h", exp, act);
            n_value_err++;
        end
    endtask

    // wait for the digit to come round before comparing its pattern
    task automatic check_seg(input logic [7:0] exp, input int digit);
        int n;
        n = 0;
        while (an !== ~(4'b0001 << digit) && n < 4 * DIGIT_PERIOD + 2) begin
            @(negedge clk);
            n++;
        end
        if (an !== ~(4'b0001 << digit)) begin
            $display("timed out waiting for digit %0d to be selected", digit);
            n_timeout_err++;
        end else if (seg !== exp) begin
            $display("CHECK FAILED seg[digit %0d]: expected %h, got %h", digit, exp, seg);
            n_value_err++;
        end
    endtask

    task automatic wait_state(input game_state_e exp);
        int n;
        n = 0;
        while (state !== exp && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (state !== exp) begin
            $display("state did not reach %h within 8 cycles", exp);
            n_timeout_err++;
        end
        check_state(exp, state);
    endtask

    task automatic check_display(input step_t s);
        int afloat;
        // hull cells not yet hit
        afloat = HULL_CELLS - int'(s.hits);
        check_seg(seg_code({1'b0, s.hits}), 0);
        check_seg(seg_code(s.shots), 1);
        check_seg(seg_code({1'b0, s.st}), 2);
        check_seg(seg_code(4'(afloat)), 3);
    endtask

    task automatic press(input logic [7:0] which);
        case (which)
            B_GAME: game_button = 1'b1;
            B_MENU: menu_button = 1'b1;
            B_VICT: victory_button = 1'b1;
            default: game_over = 1'b1;
        endcase
        @(negedge clk);
        game_button    = 1'b0;
        menu_button    = 1'b0;
        victory_button = 1'b0;
        game_over      = 1'b0;
    endtask

    task automatic fire_once();
        fire = 1'b1;
        @(negedge clk);
        fire = 1'b0;
    endtask

    // one rx frame with the data lsb first between start and stop bits
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (BAUD_DIV) @(negedge clk);
        end
    endtask

    task automatic get_tx_byte(output logic [7:0] b, output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        b  = 8'h00;
        while (tx !== 1'b0 && n < 3 * BAUD_DIV) begin
            @(negedge clk);
            n++;
        end
        if (tx !== 1'b0) begin
            $display("no frame started on tx within %0d cycles", 3 * BAUD_DIV);
            n_timeout_err++;
        end else begin
            // one sample per bit time from the middle of the start bit
            repeat (BAUD_DIV / 2) @(negedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_DIV) @(negedge clk);
                b[i] = tx;
            end
            repeat (BAUD_DIV) @(negedge clk);
            ok = (tx === 1'b1);
            if (!ok) begin
                $display("stop bit of the tx frame was low");
                n_value_err++;
            end
        end
    endtask

    task automatic expect_frame(input link_op_e exp);
        logic [7:0] b;
        logic       ok;
        get_tx_byte(b, ok);
        if (ok) begin
            check_op(exp, link_op_e'(b));
        end
    endtask

    // a whole frame time with tx resting high
    task automatic expect_quiet();
        int n;
        n = 0;
        while (tx === 1'b1 && n < FRAME) begin
            @(negedge clk);
            n++;
        end
        if (tx !== 1'b1) begin
            $display("tx started a frame when none was expected");
            n_value_err++;
        end
    endtask

    task automatic apply_step(input step_t s);
        case (s.act)
            A_IDLE: expect_quiet();
            A_PRESS: press(s.val);
            A_FIRE: begin
                for (int i = 0; i < int'(s.val); i++) begin
                    fire_once();
                    expect_frame(s.op);
                end
            end
            A_FIRE2: begin
                // second shot arrives while the first frame is starting
                fire_once();
                @(negedge clk);
                fire_once();
            end
            A_RX: send_byte(s.val);
            default: begin
            end
        endcase
        if (s.tx_chk && s.act != A_FIRE) begin
            expect_frame(s.op);
        end
        wait_state(s.st);
        if (s.disp) begin
            check_display(s);
        end
    endtask

    task automatic load_steps();
        // action, value, state, tx expected, tx op, check display, hits, shots
        steps[0]  = '{A_IDLE,    8'h00,    ST_MENU, 1'b0, OP_READY, 1'b1, 3'd0, 4'd0};
        steps[1]  = '{A_PRESS,   B_GAME,   ST_WAIT, 1'b1, OP_READY, 1'b1, 3'd0, 4'd0};
        steps[2]  = '{A_RX,      OP_READY, ST_PLAY, 1'b0, OP_READY, 1'b1, 3'd0, 4'd0};
        steps[3]  = '{A_FIRE,    8'd1,     ST_PLAY, 1'b1, OP_SHOT,  1'b1, 3'd0, 4'd1};
        steps[4]  = '{A_FIRE2,   8'h00,    ST_PLAY, 1'b1, OP_SHOT,  1'b0, 3'd0, 4'd3};
        steps[5]  = '{A_WAIT_TX, 8'h00,    ST_PLAY, 1'b1, OP_SHOT,  1'b1, 3'd0, 4'd3};
        steps[6]  = '{A_IDLE,    8'h00,    ST_PLAY, 1'b0, OP_SHOT,  1'b0, 3'd0, 4'd3};
        // counter wraps to 1 after 17 shots in all
        steps[7]  = '{A_FIRE,    8'd14,    ST_PLAY, 1'b1, OP_SHOT,  1'b1, 3'd0, 4'd1};
        steps[8]  = '{A_RX,      8'h3c,    ST_PLAY, 1'b0, OP_SHOT,  1'b1, 3'd0, 4'd1};
        steps[9]  = '{A_RX,      OP_SHOT,  ST_PLAY, 1'b0, OP_SHOT,  1'b1, 3'd1, 4'd1};
        steps[10] = '{A_RX,      OP_SHOT,  ST_PLAY, 1'b0, OP_SHOT,  1'b1, 3'd2, 4'd1};
        steps[11] = '{A_RX,      OP_SHOT,  ST_PLAY, 1'b0, OP_SHOT,  1'b1, 3'd3, 4'd1};
        steps[12] = '{A_RX,      OP_SHOT,  ST_PLAY, 1'b0, OP_SHOT,  1'b1, 3'd4, 4'd1};
        steps[13] = '{A_RX,      OP_SHOT,  ST_LOST, 1'b1, OP_LOST,  1'b1, 3'd5, 4'd1};
        steps[14] = '{A_PRESS,   B_MENU,   ST_MENU, 1'b0, OP_READY, 1'b1, 3'd0, 4'd0};
        // peer ready first this round
        steps[15] = '{A_RX,      OP_READY, ST_MENU, 1'b0, OP_READY, 1'b1, 3'd0, 4'd0};
        steps[16] = '{A_PRESS,   B_GAME,   ST_PLAY, 1'b1, OP_READY, 1'b1, 3'd0, 4'd0};
        steps[17] = '{A_FIRE,    8'd1,     ST_PLAY, 1'b1, OP_SHOT,  1'b1, 3'd0, 4'd1};
        steps[18] = '{A_RX,      OP_SHOT,  ST_PLAY, 1'b0, OP_SHOT,  1'b1, 3'd1, 4'd1};
        steps[19] = '{A_RX,      OP_LOST,  ST_WON,  1'b0, OP_LOST,  1'b1, 3'd1, 4'd1};
        steps[20] = '{A_PRESS,   B_MENU,   ST_MENU, 1'b0, OP_READY, 1'b1, 3'd0, 4'd0};
        steps[21] = '{A_PRESS,   B_OVER,   ST_LOST, 1'b1, OP_LOST,  1'b1, 3'd0, 4'd0};
        steps[22] = '{A_PRESS,   B_VICT,   ST_WON,  1'b0, OP_LOST,  1'b1, 3'd0, 4'd0};
    endtask

    initial begin
        int gap;
        clk            = 1'b0;
        rst_n          = 1'b0;
        game_button    = 1'b0;
        menu_button    = 1'b0;
        victory_button = 1'b0;
        game_over      = 1'b0;
        fire           = 1'b0;
        rx             = 1'b1;
        n_value_err    = 0;
        n_timeout_err  = 0;
        // seed the generator once
        gap = $urandom(32'hcb07);
        load_steps();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NSTEPS; i++) begin
            // back to back frames leave no room for a gap
            if (steps[i].act != A_WAIT_TX) begin
                gap = 1 + int'($urandom % 6);
                repeat (gap) @(negedge clk);
            end
            apply_step(steps[i]);
        end
        $display("errors: %0d wrong values, %0d timeouts", n_value_err, n_timeout_err);
        if (n_value_err == 0 && n_timeout_err == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* tb/game_props.sv */
`timescale 1ns/100ps

module game_props (
    input logic clk,
    input logic rst_n,
    input logic tx,
    input logic tx_busy,
    input logic peer_ready,
    input logic peer_shot,
    input logic peer_lost
);

    // line idle as soon as reset lets go
    tx_after_reset: assert property (
        @(posedge clk) (!$past(rst_n) && rst_n) |-> tx
    ) else $error("tx not high in the first cycle after reset");

    ready_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) peer_ready |=> !peer_ready
    ) else $error("peer_ready lasted more than one cycle");

    shot_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) peer_shot |=> !peer_shot
    ) else $error("peer_shot lasted more than one cycle");

    lost_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) peer_lost |=> !peer_lost
    ) else $error("peer_lost lasted more than one cycle");

    // no frame on the line, so tx rests high
    tx_idle_high: assert property (
        @(posedge clk) disable iff (!rst_n) !tx_busy |-> tx
    ) else $error("tx low while no frame is in progress");

endmodule

bind uart_link game_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx         (tx),
    .tx_busy    (tx_busy),
    .peer_ready (lnk.peer_ready),
    .peer_shot  (lnk.peer_shot),
    .peer_lost  (lnk.peer_lost)
);

/* hdl/game_top.sv */
`timescale 1ns/100ps

module game_top import game_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        game_button,
    input  logic        menu_button,
    input  logic        victory_button,
    input  logic        game_over,
    input  logic        fire,
    input  logic        rx,
    output logic        tx,
    output logic [3:0]  an,
    output logic [7:0]  seg,
    output game_state_e state
);

    // core counters for the display
    logic [2:0] hits_taken;
    logic [3:0] shots_fired;

    link_if lnk ();

    game_core u_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .game_button    (game_button),
        .menu_button    (menu_button),
        .victory_button (victory_button),
        .game_over      (game_over),
        .fire           (fire),
        .lnk            (lnk.core),
        .state          (state),
        .hits_taken     (hits_taken),
        .shots_fired    (shots_fired)
    );

    uart_link u_link (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .tx    (tx),
        .lnk   (lnk.link)
    );

    seg_display u_disp (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .hits_taken  (hits_taken),
        .shots_fired (shots_fired),
        .an          (an),
        .seg         (seg)
    );

endmodule

/* hdl/seg_display.sv */
`timescale 1ns/100ps

module seg_display import game_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  game_state_e  state,
    input  logic [2:0]   hits_taken,
    input  logic [3:0]   shots_fired,
    output logic [3:0]   an,
    output logic [7:0]   seg
);

    logic [DIGIT_W-1:0] div_cnt;
    logic [1:0]         sel;
    logic [3:0]         digit_val;

    // dwell counter and digit index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sel     <= '0;
        end else if (div_cnt == DIGIT_W'(DIGIT_PERIOD - 1)) begin
            div_cnt <= '0;
            sel     <= sel + 2'd1;
        end else begin
            div_cnt <= div_cnt + DIGIT_W'(1);
        end
    end

    always_comb begin
        case (sel)
            2'd0: digit_val = {1'b0, hits_taken};
            2'd1: digit_val = shots_fired;
            2'd2: digit_val = {1'b0, state};
            // cells still afloat
            default: digit_val = 4'(HULL_CELLS) - {1'b0, hits_taken};
        endcase
    end

    // active low select, one digit at a time
    assign an  = ~(4'b0001 << sel);
    assign seg = seg_code(digit_val);

endmodule

/* hdl/uart_link.sv */
`timescale 1ns/100ps

module uart_link import game_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic tx,
    link_if.link lnk
);

    // pending flags, index 2 lost, 1 shot, 0 ready
    logic [2:0]        pend;
    logic [2:0]        take;
    link_op_e          op_sel;
    logic              tx_busy;
    logic [8:0]        tx_data;
    logic [3:0]        tx_bits;
    logic [BAUD_W-1:0] tx_baud;

    logic              rx_s1;
    logic              rx_s2;
    logic              rx_busy;
    logic [7:0]        rx_data;
    logic [3:0]        rx_bits;
    logic [BAUD_W-1:0] rx_baud;
    logic              rx_tick;

    // highest priority pending message
    always_comb begin
        take   = 3'b000;
        op_sel = OP_READY;
        if (pend[2]) begin
            take   = 3'b100;
            op_sel = OP_LOST;
        end else if (pend[1]) begin
            take   = 3'b010;
            op_sel = OP_SHOT;
        end else if (pend[0]) begin
            take = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend    <= '0;
            tx_busy <= 1'b0;
            tx      <= 1'b1;
            tx_bits <= '0;
            tx_baud <= '0;
        end else begin
            // a new request always survives, repeats just merge
            pend <= (pend & ~(tx_busy ? 3'b000 : take))
                  | {lnk.lost_send, lnk.shot_send, lnk.ready_send};
            if (!tx_busy) begin
                if (|pend) begin
                    tx_busy <= 1'b1;
                    tx      <= 1'b0;
                    tx_data <= {1'b1, op_sel};
                    tx_bits <= '0;
                    tx_baud <= '0;
                end
            end else if (tx_baud == BAUD_W'(BAUD_DIV - 1)) begin
                tx_baud <= '0;
                if (tx_bits == 4'd9) begin
                    tx_busy <= 1'b0;
                end else begin
                    tx      <= tx_data[0];
                    tx_data <= {1'b1, tx_data[8:1]};
                    tx_bits <= tx_bits + 4'd1;
                end
            end else begin
                tx_baud <= tx_baud + BAUD_W'(1);
            end
        end
    end

    assign rx_tick = rx_busy && (rx_baud == BAUD_W'(BAUD_DIV - 1));

    // receiver, samples mid bit off the synchronized line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_s1          <= 1'b1;
            rx_s2          <= 1'b1;
            rx_busy        <= 1'b0;
            rx_bits        <= '0;
            rx_baud        <= '0;
            lnk.peer_ready <= 1'b0;
            lnk.peer_shot  <= 1'b0;
            lnk.peer_lost  <= 1'b0;
        end else begin
            rx_s1          <= rx;
            rx_s2          <= rx_s1;
            lnk.peer_ready <= 1'b0;
            lnk.peer_shot  <= 1'b0;
            lnk.peer_lost  <= 1'b0;
            if (!rx_busy) begin
                if (!rx_s2) begin
                    rx_busy <= 1'b1;
                    rx_bits <= '0;
                    rx_baud <= BAUD_W'(BAUD_DIV / 2);
                end
            end else if (rx_tick) begin
                rx_baud <= '0;
                rx_bits <= rx_bits + 4'd1;
                if (rx_bits == 4'd0) begin
                    // glitch, not a real start bit
                    if (rx_s2) begin
                        rx_busy <= 1'b0;
                    end
                end else if (rx_bits == 4'd9) begin
                    rx_busy <= 1'b0;
                    if (rx_s2) begin
                        lnk.peer_ready <= (rx_data == OP_READY);
                        lnk.peer_shot  <= (rx_data == OP_SHOT);
                        lnk.peer_lost  <= (rx_data == OP_LOST);
                    end
                end else begin
                    rx_data <= {rx_s2, rx_data[7:1]};
                end
            end else begin
                rx_baud <= rx_baud + BAUD_W'(1);
            end
        end
    end

endmodule

/* hdl/game_core.sv */
`timescale 1ns/100ps

module game_core import game_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        game_button,
    input  logic        menu_button,
    input  logic        victory_button,
    input  logic        game_over,
    input  logic        fire,
    link_if.core        lnk,
    output game_state_e state,
    output logic [2:0]  hits_taken,
    output logic [3:0]  shots_fired
);

    game_state_e state_d;
    logic [2:0]  hits_d;
    logic [3:0]  shots_d;
    logic        ready_d;
    logic        shot_d;
    logic        lost_d;
    logic        peer_rdy_q;
    logic        rdy_seen;
    logic        in_round;
    logic        in_round_d;

    // peer may have announced itself before our own game_button
    assign rdy_seen   = peer_rdy_q | lnk.peer_ready;
    assign in_round   = (state == ST_WAIT) || (state == ST_PLAY);
    assign in_round_d = (state_d == ST_WAIT) || (state_d == ST_PLAY);

    always_comb begin
        state_d = state;
        hits_d  = hits_taken;
        shots_d = shots_fired;
        ready_d = 1'b0;
        shot_d  = 1'b0;
        lost_d  = 1'b0;
        if (menu_button) begin
            state_d = ST_MENU;
            hits_d  = '0;
            shots_d = '0;
        end else if (game_over) begin
            state_d = ST_LOST;
            // tell the peer only once
            lost_d  = (state != ST_LOST);
        end else if (victory_button) begin
            state_d = ST_WON;
        end else begin
            case (state)
                ST_MENU: begin
                    if (game_button) begin
                        ready_d = 1'b1;
                        state_d = rdy_seen ? ST_PLAY : ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (lnk.peer_ready) begin
                        state_d = ST_PLAY;
                    end
                end
                ST_PLAY: begin
                    if (fire) begin
                        shot_d  = 1'b1;
                        shots_d = shots_fired + 4'd1;
                    end
                    if (lnk.peer_lost) begin
                        state_d = ST_WON;
                    end else if (lnk.peer_shot) begin
                        hits_d = hits_taken + 3'd1;
                        // last hull cell gone
                        if (hits_taken == 3'(HULL_CELLS - 1)) begin
                            state_d = ST_LOST;
                            lost_d  = 1'b1;
                        end
                    end
                end
                default: begin
                    state_d = state;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= ST_MENU;
            hits_taken     <= '0;
            shots_fired    <= '0;
            peer_rdy_q     <= 1'b0;
            lnk.ready_send <= 1'b0;
            lnk.shot_send  <= 1'b0;
            lnk.lost_send  <= 1'b0;
        end else begin
            state          <= state_d;
            hits_taken     <= hits_d;
            shots_fired    <= shots_d;
            lnk.ready_send <= ready_d;
            lnk.shot_send  <= shot_d;
            lnk.lost_send  <= lost_d;
            if (in_round && !in_round_d) begin
                peer_rdy_q <= 1'b0;
            end else if (lnk.peer_ready) begin
                peer_rdy_q <= 1'b1;
            end
        end
    end

endmodule

/* hdl/link_if.sv */
`timescale 1ns/100ps

interface link_if;

    // core to link, each a single-cycle request to send
    logic ready_send;
    logic shot_send;
    logic lost_send;

    // link to core, one pulse per decoded peer message
    logic peer_ready;
    logic peer_shot;
    logic peer_lost;

    modport core (
        output ready_send,
        output shot_send,
        output lost_send,
        input  peer_ready,
        input  peer_shot,
        input  peer_lost
    );

    modport link (
        input  ready_send,
        input  shot_send,
        input  lost_send,
        output peer_ready,
        output peer_shot,
        output peer_lost
    );

endinterface

/* hdl/game_pkg.sv */
package game_pkg;

    // game states, value shown on display digit 2
    typedef enum logic [2:0] {
        ST_MENU = 3'd0,
        ST_WAIT = 3'd1,
        ST_PLAY = 3'd2,
        ST_WON  = 3'd3,
        ST_LOST = 3'd4
    } game_state_e;

    // one-byte messages exchanged with the peer board
    typedef enum logic [7:0] {
        OP_READY = 8'ha5,
        OP_SHOT  = 8'h5a,
        OP_LOST  = 8'hc3
    } link_op_e;

    localparam int BAUD_DIV     = 16;
    localparam int BAUD_W       = $clog2(BAUD_DIV);
    localparam int HULL_CELLS   = 5;
    localparam int DIGIT_PERIOD = 8;
    localparam int DIGIT_W      = $clog2(DIGIT_PERIOD);

    // active low, bit 7 is the decimal point, bits 6..0 are g..a
    function automatic logic [7:0] seg_code(input logic [3:0] value);
        logic [7:0] pattern;
        case (value)
            4'h0: pattern = 8'hc0;
            4'h1: pattern = 8'hf9;
            4'h2: pattern = 8'ha4;
            4'h3: pattern = 8'hb0;
            4'h4: pattern = 8'h99;
            4'h5: pattern = 8'h92;
            4'h6: pattern = 8'h82;
            4'h7: pattern = 8'hf8;
            4'h8: pattern = 8'h80;
            4'h9: pattern = 8'h90;
            4'ha: pattern = 8'h88;
            4'hb: pattern = 8'h83;
            4'hc: pattern = 8'hc6;
            4'hd: pattern = 8'ha1;
            4'he: pattern = 8'h86;
            default: pattern = 8'h8e;
        endcase
        return pattern;
    endfunction

endpackage
